/* branch_unit.sv */
module branch_unit (
  input  logic               clk,
  input  logic               reset,
  input  logic               valid,
  input  logic               pause,
  input  id_pkg::dec_ctrl_t  dec,
  input  id_pkg::cmp_flags_t cmp,
  input  id_pkg::word_t      pc,
  input  id_pkg::word_t      rj_value,
  output id_pkg::br_bus_t    br
);
  import id_pkg::*;

  logic  cond;
  logic  stall;
  logic  taken;
  logic  taken_last;
  word_t offs16;
  word_t offs26;
  word_t target;

  // Word offsets, shifted left by two
  assign offs16 = {{14{dec.imm_field[25]}}, dec.imm_field[25:10], 2'b00};
  assign offs26 = {{4{dec.imm_field[9]}}, dec.imm_field[9:0], dec.imm_field[25:10], 2'b00};

  always_comb
  begin
    case (dec.br_kind)
      BR_BEQ:                 cond = cmp.eq;
      BR_BNE:                 cond = ~cmp.eq;
      BR_BLT:                 cond = cmp.lt_s;
      BR_BGE:                 cond = ~cmp.lt_s;
      BR_BLTU:                cond = cmp.lt_u;
      BR_BGEU:                cond = ~cmp.lt_u;
      BR_B, BR_BL, BR_JIRL:   cond = 1'b1;
      default:                cond = 1'b0;
    endcase
  end

  always_comb
  begin
    case (dec.br_kind)
      BR_JIRL:     target = rj_value + offs16;
      BR_B, BR_BL: target = pc + offs26;
      default:     target = pc + offs16;
    endcase
  end

  // Operands may be stale under a hazard, so the branch waits
  assign stall = pause & (dec.br_kind != BR_NONE);
  assign taken = cond & valid & ~stall;

  // Remembers last cycle's taken so a held branch redirects fetch once
  always_ff @(posedge clk)
  begin
    if (reset)
      taken_last <= 1'b0;
    else
      taken_last <= taken;
  end

  assign br = '{target: target, taken_pulse: taken & ~taken_last, stall: stall};

endmodule

/* id_checker.sv */
module id_checker (
  input logic               clk,
  input logic               reset,
  input logic               valid,
  input id_pkg::inst_pc_t   inst_pc,
  input logic               ex_allow_in,
  input logic               pause,
  input logic               fwd1_hit,
  input logic               fwd2_hit,
  input id_pkg::word_t      fwd1_data,
  input id_pkg::word_t      fwd2_data,
  input id_pkg::word_t      rf_rdata1,
  input id_pkg::word_t      rf_rdata2,
  input id_pkg::reg_addr_t  rf_raddr1,
  input id_pkg::reg_addr_t  rf_raddr2,
  input logic               id_valid,
  input id_pkg::id_ex_t     id_ex,
  input id_pkg::br_bus_t    br,
  input logic               ready_go,
  input logic               allow_in
);
  timeunit 1ns;
  timeprecision 1ps;
  import id_pkg::*;

  int fail_count = 0;

  word_t      w;
  logic [5:0] op6;
  logic [3:0] op4;
  logic [1:0] op2;
  logic [4:0] f5;
  logic       is_alu_si12;
  logic       is_alu_ui12;
  logic       is_shift_i;
  logic       is_reg3;
  logic       is_div;
  logic       is_sys;
  logic       is_brk;
  logic       is_upper;
  logic       is_mem;
  logic       is_store;
  logic       is_br;
  logic       is_cbr;
  logic       is_link;
  logic       pc_rel;
  logic       known;
  logic       src2_known;
  logic       cond;
  logic       taken_now;
  logic       prev_taken;
  word_t      rj_sel;
  word_t      rkd_sel;
  word_t      exp_src1;
  word_t      exp_src2;
  word_t      off16;
  word_t      off26;
  word_t      exp_target;
  reg_addr_t  exp_raddr2;
  exc_vec_t   exp_exc;

  assign w   = inst_pc.inst;
  assign op6 = w[31:26];
  assign op4 = w[25:22];
  assign op2 = w[21:20];
  assign f5  = w[19:15];

  // Independent view of which instruction is present
  assign is_alu_si12 = op6 == OP6_ALU && op4 inside {OP4_SLTI, OP4_SLTUI, OP4_ADDI};
  assign is_alu_ui12 = op6 == OP6_ALU && op4 inside {OP4_ANDI, OP4_ORI, OP4_XORI};
  assign is_shift_i  = op6 == OP6_ALU && op4 == OP4_SHIFT_I && op2 == OP2_SHIFT_I
                       && f5 inside {F5_SLLI, F5_SRLI, F5_SRAI};
  assign is_reg3     = op6 == OP6_ALU && op4 == OP4_REG && op2 == OP2_3R
                       && f5 inside {F5_ADD, F5_SUB, F5_SLT, F5_SLTU, F5_NOR, F5_AND, F5_OR,
                                     F5_XOR, F5_SLL, F5_SRL, F5_SRA, F5_MUL, F5_MULH, F5_MULHU};
  assign is_div      = op6 == OP6_ALU && op4 == OP4_REG && op2 == OP2_DIV
                       && f5 inside {F5_DIV, F5_MOD, F5_DIVU, F5_MODU};
  assign is_sys      = op6 == OP6_ALU && op4 == OP4_REG && op2 == OP2_DIV && f5 == F5_SYSCALL;
  assign is_brk      = op6 == OP6_ALU && op4 == OP4_REG && op2 == OP2_DIV && f5 == F5_BREAK;
  assign is_upper    = op6 inside {OP6_LU12I, OP6_PCADDU12I} && !w[25];
  assign is_mem      = op6 == OP6_MEM && op4 inside {OP4_LD_B, OP4_LD_H, OP4_LD_W, OP4_ST_B,
                                                    OP4_ST_H, OP4_ST_W, OP4_LD_BU, OP4_LD_HU};
  assign is_store    = op6 == OP6_MEM && op4 inside {OP4_ST_B, OP4_ST_H, OP4_ST_W};
  assign is_br       = op6 inside {[OP6_JIRL:OP6_BGEU]};
  assign is_cbr      = op6 inside {[OP6_BEQ:OP6_BGEU]};
  assign is_link     = op6 inside {OP6_BL, OP6_JIRL};
  assign pc_rel      = op6 == OP6_PCADDU12I || is_link;
  assign known       = is_alu_si12 | is_alu_ui12 | is_shift_i | is_reg3 | is_div | is_sys
                       | is_brk | is_upper | is_mem | is_br;

  assign rj_sel   = fwd1_hit ? fwd1_data : rf_rdata1;
  assign rkd_sel  = fwd2_hit ? fwd2_data : rf_rdata2;
  assign exp_src1 = pc_rel ? inst_pc.pc : rj_sel;

  // Stores and compare branches read rd on the second port
  assign exp_raddr2 = (is_store || is_cbr) ? w[4:0] : w[14:10];

  always_comb
  begin
    src2_known = 1'b1;
    exp_src2 = '0;
    if (is_alu_si12 || is_mem)
      exp_src2 = {{20{w[21]}}, w[21:10]};
    else if (is_alu_ui12)
      exp_src2 = {20'b0, w[21:10]};
    else if (is_shift_i)
      exp_src2 = {27'b0, w[14:10]};
    else if (is_upper)
      exp_src2 = {w[24:5], 12'b0};
    else if (is_link)
      exp_src2 = 32'd4;
    else if (is_reg3 || is_div)
      exp_src2 = rkd_sel;
    else
      src2_known = 1'b0;
  end

  always_comb
  begin
    case (op6)
      OP6_BEQ:                    cond = rj_sel == rkd_sel;
      OP6_BNE:                    cond = rj_sel != rkd_sel;
      OP6_BLT:                    cond = $signed(rj_sel) < $signed(rkd_sel);
      OP6_BGE:                    cond = $signed(rj_sel) >= $signed(rkd_sel);
      OP6_BLTU:                   cond = rj_sel < rkd_sel;
      OP6_BGEU:                   cond = rj_sel >= rkd_sel;
      OP6_B, OP6_BL, OP6_JIRL:    cond = 1'b1;
      default:                    cond = 1'b0;
    endcase
  end

  // Branch offsets count instructions, hence the two zero bits
  assign off16 = {{14{w[25]}}, w[25:10], 2'b00};
  assign off26 = {{4{w[9]}}, w[9:0], w[25:10], 2'b00};
  assign exp_target = (op6 == OP6_JIRL) ? rj_sel + off16 :
                      (op6 inside {OP6_B, OP6_BL}) ? inst_pc.pc + off26 :
                      inst_pc.pc + off16;

  assign taken_now = valid & ~pause & cond;
  assign exp_exc   = '{sys: valid & is_sys, brk: valid & is_brk, ine: valid & ~known};

  always_ff @(posedge clk)
  begin
    if (reset)
      prev_taken <= 1'b0;
    else
      prev_taken <= taken_now;
  end

  raddr1_field: assert property (@(posedge clk) disable iff (reset)
    rf_raddr1 == w[9:5])
  else
  begin
    fail_count++;
    $error("mismatch at %0t: rf_raddr1 = %0d, expected %0d", $time, rf_raddr1, w[9:5]);
  end

  raddr2_field: assert property (@(posedge clk) disable iff (reset)
    rf_raddr2 == exp_raddr2)
  else
  begin
    fail_count++;
    $error("mismatch at %0t: rf_raddr2 = %0d, expected %0d", $time, rf_raddr2, exp_raddr2);
  end

  src2_sel: assert property (@(posedge clk) disable iff (reset)
    src2_known |-> id_ex.alu_src2 == exp_src2)
  else
  begin
    fail_count++;
    $error("mismatch at %0t: id_ex.alu_src2 = %h, expected %h", $time, id_ex.alu_src2,
           exp_src2);
  end

  src1_sel: assert property (@(posedge clk) disable iff (reset)
    id_ex.alu_src1 == exp_src1)
  else
  begin
    fail_count++;
    $error("mismatch at %0t: id_ex.alu_src1 = %h, expected %h", $time, id_ex.alu_src1,
           exp_src1);
  end

  store_data: assert property (@(posedge clk) disable iff (reset)
    id_ex.mem.st_data == rkd_sel)
  else
  begin
    fail_count++;
    $error("mismatch at %0t: id_ex.mem.st_data = %h, expected %h", $time, id_ex.mem.st_data,
           rkd_sel);
  end

  br_target: assert property (@(posedge clk) disable iff (reset)
    taken_now |-> br.target == exp_target)
  else
  begin
    fail_count++;
    $error("mismatch at %0t: br.target = %h, expected %h", $time, br.target, exp_target);
  end

  // A held taken branch redirects fetch only once
  taken_pulse_once: assert property (@(posedge clk) disable iff (reset)
    br.taken_pulse == (taken_now & ~prev_taken))
  else
  begin
    fail_count++;
    $error("mismatch at %0t: br.taken_pulse = %b, expected %b", $time, br.taken_pulse,
           taken_now & ~prev_taken);
  end

  stall_level: assert property (@(posedge clk) disable iff (reset)
    br.stall == (pause & is_br))
  else
  begin
    fail_count++;
    $error("mismatch at %0t: br.stall = %b, expected %b", $time, br.stall, pause & is_br);
  end

  ready_level: assert property (@(posedge clk) disable iff (reset)
    ready_go == !pause)
  else
  begin
    fail_count++;
    $error("mismatch at %0t: ready_go = %b, expected %b", $time, ready_go, !pause);
  end

  exc_flags: assert property (@(posedge clk) disable iff (reset)
    id_ex.exc == exp_exc)
  else
  begin
    fail_count++;
    $error("mismatch at %0t: id_ex.exc = %b, expected %b", $time, id_ex.exc, exp_exc);
  end

  valid_out: assert property (@(posedge clk) disable iff (reset)
    id_valid == (valid & known))
  else
  begin
    fail_count++;
    $error("mismatch at %0t: id_valid = %b, expected %b", $time, id_valid, valid & known);
  end

  allow_level: assert property (@(posedge clk) disable iff (reset)
    allow_in == (!id_valid || (ex_allow_in && ready_go)))
  else
  begin
    fail_count++;
    $error("mismatch at %0t: allow_in = %b, expected %b", $time, allow_in,
           !id_valid || (ex_allow_in && ready_go));
  end

  no_writeback: assert property (@(posedge clk) disable iff (reset)
    valid && (is_store || (is_br && !is_link)) |-> !id_ex.rf_we)
  else
  begin
    fail_count++;
    $error("mismatch at %0t: id_ex.rf_we = %b, expected 0", $time, id_ex.rf_we);
  end

  link_dest: assert property (@(posedge clk) disable iff (reset)
    valid && op6 == OP6_BL |-> id_ex.rf_we && id_ex.rf_waddr == 5'd1)
  else
  begin
    fail_count++;
    $error("mismatch at %0t: id_ex.rf_we = %b, id_ex.rf_waddr = %0d, expected 1 and 1",
           $time, id_ex.rf_we, id_ex.rf_waddr);
  end

endmodule

bind id_stage id_checker u_checker (
  .clk         (clk),
  .reset       (reset),
  .valid       (valid),
  .inst_pc     (inst_pc),
  .ex_allow_in (ex_allow_in),
  .pause       (pause),
  .fwd1_hit    (fwd1_hit),
  .fwd2_hit    (fwd2_hit),
  .fwd1_data   (fwd1_data),
  .fwd2_data   (fwd2_data),
  .rf_rdata1   (rf_rdata1),
  .rf_rdata2   (rf_rdata2),
  .rf_raddr1   (rf_raddr1),
  .rf_raddr2   (rf_raddr2),
  .id_valid    (id_valid),
  .id_ex       (id_ex),
  .br          (br),
  .ready_go    (ready_go),
  .allow_in    (allow_in)
);

/* id_pkg.sv */
package id_pkg;

  typedef logic [4:0]  reg_addr_t;
  typedef logic [31:0] word_t;
  typedef logic [11:0] alu_op_t;

  // One-hot ALU positions, low bits double as mul/div selectors
  localparam int ALU_ADD  = 0;
  localparam int ALU_SUB  = 1;
  localparam int ALU_SLT  = 2;
  localparam int ALU_SLTU = 3;
  localparam int ALU_AND  = 4;
  localparam int ALU_NOR  = 5;
  localparam int ALU_OR   = 6;
  localparam int ALU_XOR  = 7;
  localparam int ALU_SLL  = 8;
  localparam int ALU_SRL  = 9;
  localparam int ALU_SRA  = 10;
  localparam int ALU_LUI  = 11;

  // Major opcode in bits 31:26
  localparam logic [5:0] OP6_ALU       = 6'h00;
  localparam logic [5:0] OP6_LU12I     = 6'h05;
  localparam logic [5:0] OP6_PCADDU12I = 6'h07;
  localparam logic [5:0] OP6_MEM       = 6'h0a;
  localparam logic [5:0] OP6_JIRL      = 6'h13;
  localparam logic [5:0] OP6_B         = 6'h14;
  localparam logic [5:0] OP6_BL        = 6'h15;
  localparam logic [5:0] OP6_BEQ       = 6'h16;
  localparam logic [5:0] OP6_BNE       = 6'h17;
  localparam logic [5:0] OP6_BLT       = 6'h18;
  localparam logic [5:0] OP6_BGE       = 6'h19;
  localparam logic [5:0] OP6_BLTU      = 6'h1a;
  localparam logic [5:0] OP6_BGEU      = 6'h1b;

  // Bits 25:22 under the ALU major opcode
  localparam logic [3:0] OP4_REG     = 4'h0;
  localparam logic [3:0] OP4_SHIFT_I = 4'h1;
  localparam logic [3:0] OP4_SLTI    = 4'h8;
  localparam logic [3:0] OP4_SLTUI   = 4'h9;
  localparam logic [3:0] OP4_ADDI    = 4'ha;
  localparam logic [3:0] OP4_ANDI    = 4'hd;
  localparam logic [3:0] OP4_ORI     = 4'he;
  localparam logic [3:0] OP4_XORI    = 4'hf;

  // Bits 25:22 under the memory major opcode
  localparam logic [3:0] OP4_LD_B  = 4'h0;
  localparam logic [3:0] OP4_LD_H  = 4'h1;
  localparam logic [3:0] OP4_LD_W  = 4'h2;
  localparam logic [3:0] OP4_ST_B  = 4'h4;
  localparam logic [3:0] OP4_ST_H  = 4'h5;
  localparam logic [3:0] OP4_ST_W  = 4'h6;
  localparam logic [3:0] OP4_LD_BU = 4'h8;
  localparam logic [3:0] OP4_LD_HU = 4'h9;

  // Bits 21:20
  localparam logic [1:0] OP2_SHIFT_I = 2'h0;
  localparam logic [1:0] OP2_3R      = 2'h1;
  localparam logic [1:0] OP2_DIV     = 2'h2;

  // Bits 19:15, three-register group
  localparam logic [4:0] F5_ADD   = 5'h00;
  localparam logic [4:0] F5_SUB   = 5'h02;
  localparam logic [4:0] F5_SLT   = 5'h04;
  localparam logic [4:0] F5_SLTU  = 5'h05;
  localparam logic [4:0] F5_NOR   = 5'h08;
  localparam logic [4:0] F5_AND   = 5'h09;
  localparam logic [4:0] F5_OR    = 5'h0a;
  localparam logic [4:0] F5_XOR   = 5'h0b;
  localparam logic [4:0] F5_SLL   = 5'h0e;
  localparam logic [4:0] F5_SRL   = 5'h0f;
  localparam logic [4:0] F5_SRA   = 5'h10;
  localparam logic [4:0] F5_MUL   = 5'h18;
  localparam logic [4:0] F5_MULH  = 5'h19;
  localparam logic [4:0] F5_MULHU = 5'h1a;

  // Bits 19:15, divide and trap group
  localparam logic [4:0] F5_DIV     = 5'h00;
  localparam logic [4:0] F5_MOD     = 5'h01;
  localparam logic [4:0] F5_DIVU    = 5'h02;
  localparam logic [4:0] F5_MODU    = 5'h03;
  localparam logic [4:0] F5_BREAK   = 5'h14;
  localparam logic [4:0] F5_SYSCALL = 5'h16;

  // Bits 19:15, shift-immediate group
  localparam logic [4:0] F5_SLLI = 5'h01;
  localparam logic [4:0] F5_SRLI = 5'h09;
  localparam logic [4:0] F5_SRAI = 5'h11;

  // Return address offset for bl and jirl
  localparam word_t LINK_OFFSET = 32'd4;

  typedef struct packed {
    logic [5:0] op_31_26;
    logic [3:0] op_25_22;
    logic [1:0] op_21_20;
    logic [4:0] op_19_15;
    logic [4:0] f14_10;
    logic [4:0] f9_5;
    logic [4:0] f4_0;
  } opc_view_t;

  // i12, i16, i20 and the i26 pieces are assembled from these
  typedef struct packed {
    logic [5:0] op;
    logic [3:0] i16_hi;
    logic [6:0] i12_hi;
    reg_addr_t  rk;
    reg_addr_t  rj;
    reg_addr_t  rd;
  } opd_view_t;

  typedef union packed {
    opc_view_t opc;
    opd_view_t opd;
  } inst_u;

  typedef enum logic [2:0] {
    IMM_NONE, IMM_UI5, IMM_UI12, IMM_SI12, IMM_SI20, IMM_FOUR
  } imm_kind_t;

  typedef enum logic [3:0] {
    BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU, BR_B, BR_BL, BR_JIRL
  } br_kind_t;

  typedef struct packed {
    logic       mem_en;
    logic [2:0] st_ctrl;
    logic [4:0] ld_ctrl;
    word_t      st_data;
  } mem_ctrl_t;

  typedef struct packed {
    logic sys;
    logic brk;
    logic ine;
  } exc_vec_t;

  typedef struct packed {
    alu_op_t    alu_op;
    imm_kind_t  imm_kind;
    br_kind_t   br_kind;
    logic       src1_is_pc;
    logic       src2_is_imm;
    logic       mul;
    logic       div;
    logic       res_from_mem;
    logic       gr_we;
    logic       mem_en;
    logic [2:0] st_ctrl;
    logic [4:0] ld_ctrl;
    reg_addr_t  dest;
    // Raw bits 25:0 of the instruction
    logic [25:0] imm_field;
  } dec_ctrl_t;

  typedef struct packed {
    logic eq;
    logic lt_s;
    logic lt_u;
  } cmp_flags_t;

  typedef struct packed {
    word_t target;
    logic  taken_pulse;
    logic  stall;
  } br_bus_t;

  typedef struct packed {
    alu_op_t   alu_op;
    word_t     alu_src1;
    word_t     alu_src2;
    logic      mul;
    logic      div;
    exc_vec_t  exc;
    mem_ctrl_t mem;
    logic      rf_we;
    logic      res_from_mem;
    reg_addr_t rf_waddr;
    word_t     pc;
  } id_ex_t;

  typedef struct packed {
    inst_u inst;
    word_t pc;
  } inst_pc_t;

endpackage

/* id_stage.sv */
module id_stage (
  input  logic              clk,
  input  logic              reset,
  input  logic              valid,
  input  id_pkg::inst_pc_t  inst_pc,
  input  logic              ex_allow_in,
  input  logic              pause,
  input  logic              fwd1_hit,
  input  logic              fwd2_hit,
  input  id_pkg::word_t     fwd1_data,
  input  id_pkg::word_t     fwd2_data,
  input  id_pkg::word_t     rf_rdata1,
  input  id_pkg::word_t     rf_rdata2,
  output id_pkg::reg_addr_t rf_raddr1,
  output id_pkg::reg_addr_t rf_raddr2,
  output logic              id_valid,
  output id_pkg::id_ex_t    id_ex,
  output id_pkg::br_bus_t   br,
  output logic              ready_go,
  output logic              allow_in
);
  import id_pkg::*;

  dec_ctrl_t  dec;
  exc_vec_t   exc;
  word_t      rj_value;
  word_t      rkd_value;
  cmp_flags_t cmp;

  inst_decoder u_decoder (
    .inst      (inst_pc.inst),
    .valid     (valid),
    .dec       (dec),
    .rf_raddr1 (rf_raddr1),
    .rf_raddr2 (rf_raddr2),
    .exc       (exc)
  );

  // Operand read runs beside decode
  operand_fetch u_operands (
    .rf_rdata1 (rf_rdata1),
    .rf_rdata2 (rf_rdata2),
    .fwd1_hit  (fwd1_hit),
    .fwd2_hit  (fwd2_hit),
    .fwd1_data (fwd1_data),
    .fwd2_data (fwd2_data),
    .rj_value  (rj_value),
    .rkd_value (rkd_value),
    .cmp       (cmp)
  );

  branch_unit u_branch (
    .clk      (clk),
    .reset    (reset),
    .valid    (valid),
    .pause    (pause),
    .dec      (dec),
    .cmp      (cmp),
    .pc       (inst_pc.pc),
    .rj_value (rj_value),
    .br       (br)
  );

  issue_pack u_issue (
    .valid       (valid),
    .pause       (pause),
    .ex_allow_in (ex_allow_in),
    .dec         (dec),
    .exc         (exc),
    .pc          (inst_pc.pc),
    .rj_value    (rj_value),
    .rkd_value   (rkd_value),
    .id_ex       (id_ex),
    .id_valid    (id_valid),
    .ready_go    (ready_go),
    .allow_in    (allow_in)
  );

endmodule

/* inst_decoder.sv */
module inst_decoder (
  input  id_pkg::inst_u     inst,
  input  logic              valid,
  output id_pkg::dec_ctrl_t dec,
  output id_pkg::reg_addr_t rf_raddr1,
  output id_pkg::reg_addr_t rf_raddr2,
  output id_pkg::exc_vec_t  exc
);
  import id_pkg::*;

  logic hit;
  logic src_is_rd;
  logic no_wb;
  logic is_sys;
  logic is_brk;

  always_comb
  begin
    dec = '0;
    dec.dest = inst.opd.rd;
    dec.imm_field = {inst.opd.i16_hi, inst.opd.i12_hi, inst.opd.rk, inst.opd.rj, inst.opd.rd};
    hit = 1'b1;
    src_is_rd = 1'b0;
    no_wb = 1'b0;
    is_sys = 1'b0;
    is_brk = 1'b0;
    case (inst.opc.op_31_26)
      OP6_ALU:
      begin
        if (inst.opc.op_25_22 == OP4_REG && inst.opc.op_21_20 == OP2_3R)
        begin
          case (inst.opc.op_19_15)
            F5_ADD:   dec.alu_op[ALU_ADD] = 1'b1;
            F5_SUB:   dec.alu_op[ALU_SUB] = 1'b1;
            F5_SLT:   dec.alu_op[ALU_SLT] = 1'b1;
            F5_SLTU:  dec.alu_op[ALU_SLTU] = 1'b1;
            F5_NOR:   dec.alu_op[ALU_NOR] = 1'b1;
            F5_AND:   dec.alu_op[ALU_AND] = 1'b1;
            F5_OR:    dec.alu_op[ALU_OR] = 1'b1;
            F5_XOR:   dec.alu_op[ALU_XOR] = 1'b1;
            F5_SLL:   dec.alu_op[ALU_SLL] = 1'b1;
            F5_SRL:   dec.alu_op[ALU_SRL] = 1'b1;
            F5_SRA:   dec.alu_op[ALU_SRA] = 1'b1;
            // Multiplier selector in the low bits
            F5_MUL:   dec.alu_op[0] = 1'b1;
            F5_MULH:  dec.alu_op[1] = 1'b1;
            F5_MULHU: dec.alu_op[2] = 1'b1;
            default:  hit = 1'b0;
          endcase
          dec.mul = inst.opc.op_19_15 inside {F5_MUL, F5_MULH, F5_MULHU};
        end
        else if (inst.opc.op_25_22 == OP4_REG && inst.opc.op_21_20 == OP2_DIV)
        begin
          case (inst.opc.op_19_15)
            F5_DIV:     dec.alu_op[0] = 1'b1;
            F5_DIVU:    dec.alu_op[1] = 1'b1;
            F5_MOD:     dec.alu_op[2] = 1'b1;
            F5_MODU:    dec.alu_op[3] = 1'b1;
            F5_BREAK:   is_brk = 1'b1;
            F5_SYSCALL: is_sys = 1'b1;
            default:    hit = 1'b0;
          endcase
          dec.div = inst.opc.op_19_15 inside {F5_DIV, F5_MOD, F5_DIVU, F5_MODU};
          no_wb = is_sys | is_brk;
        end
        else if (inst.opc.op_25_22 == OP4_SHIFT_I && inst.opc.op_21_20 == OP2_SHIFT_I)
        begin
          dec.imm_kind = IMM_UI5;
          case (inst.opc.op_19_15)
            F5_SLLI: dec.alu_op[ALU_SLL] = 1'b1;
            F5_SRLI: dec.alu_op[ALU_SRL] = 1'b1;
            F5_SRAI: dec.alu_op[ALU_SRA] = 1'b1;
            default: hit = 1'b0;
          endcase
        end
        else
        begin
          // Logic immediates are zero-extended, the rest sign-extended
          if (inst.opc.op_25_22 inside {OP4_ANDI, OP4_ORI, OP4_XORI})
            dec.imm_kind = IMM_UI12;
          else
            dec.imm_kind = IMM_SI12;
          case (inst.opc.op_25_22)
            OP4_SLTI:  dec.alu_op[ALU_SLT] = 1'b1;
            OP4_SLTUI: dec.alu_op[ALU_SLTU] = 1'b1;
            OP4_ADDI:  dec.alu_op[ALU_ADD] = 1'b1;
            OP4_ANDI:  dec.alu_op[ALU_AND] = 1'b1;
            OP4_ORI:   dec.alu_op[ALU_OR] = 1'b1;
            OP4_XORI:  dec.alu_op[ALU_XOR] = 1'b1;
            default:   hit = 1'b0;
          endcase
        end
      end
      OP6_LU12I:
      begin
        // Bit 25 must be clear
        hit = ~inst.opd.i16_hi[3];
        dec.imm_kind = IMM_SI20;
        dec.alu_op[ALU_LUI] = 1'b1;
      end
      OP6_PCADDU12I:
      begin
        hit = ~inst.opd.i16_hi[3];
        dec.imm_kind = IMM_SI20;
        dec.alu_op[ALU_ADD] = 1'b1;
        dec.src1_is_pc = 1'b1;
      end
      OP6_MEM:
      begin
        dec.imm_kind = IMM_SI12;
        dec.alu_op[ALU_ADD] = 1'b1;
        case (inst.opc.op_25_22)
          OP4_LD_W:  dec.ld_ctrl = 5'b10000;
          OP4_LD_B:  dec.ld_ctrl = 5'b01000;
          OP4_LD_BU: dec.ld_ctrl = 5'b00100;
          OP4_LD_H:  dec.ld_ctrl = 5'b00010;
          OP4_LD_HU: dec.ld_ctrl = 5'b00001;
          OP4_ST_W:  dec.st_ctrl = 3'b100;
          OP4_ST_H:  dec.st_ctrl = 3'b010;
          OP4_ST_B:  dec.st_ctrl = 3'b001;
          default:   hit = 1'b0;
        endcase
        dec.res_from_mem = |dec.ld_ctrl;
        dec.mem_en = (|dec.ld_ctrl) | (|dec.st_ctrl);
        src_is_rd = |dec.st_ctrl;
        no_wb = |dec.st_ctrl;
      end
      OP6_JIRL:
      begin
        dec.br_kind = BR_JIRL;
        dec.imm_kind = IMM_FOUR;
        dec.alu_op[ALU_ADD] = 1'b1;
        dec.src1_is_pc = 1'b1;
      end
      OP6_BL:
      begin
        dec.br_kind = BR_BL;
        dec.imm_kind = IMM_FOUR;
        dec.alu_op[ALU_ADD] = 1'b1;
        dec.src1_is_pc = 1'b1;
        dec.dest = 5'd1;
      end
      OP6_B:    dec.br_kind = BR_B;
      OP6_BEQ:  dec.br_kind = BR_BEQ;
      OP6_BNE:  dec.br_kind = BR_BNE;
      OP6_BLT:  dec.br_kind = BR_BLT;
      OP6_BGE:  dec.br_kind = BR_BGE;
      OP6_BLTU: dec.br_kind = BR_BLTU;
      OP6_BGEU: dec.br_kind = BR_BGEU;
      default:  hit = 1'b0;
    endcase
    // Conditional branches compare rj against rd
    if (dec.br_kind inside {[BR_BEQ:BR_BGEU]})
      src_is_rd = 1'b1;
    if (dec.br_kind inside {[BR_BEQ:BR_B]})
      no_wb = 1'b1;
    dec.src2_is_imm = dec.imm_kind != IMM_NONE;
    dec.gr_we = hit & ~no_wb;
  end

  assign rf_raddr1 = inst.opd.rj;
  assign rf_raddr2 = src_is_rd ? inst.opd.rd : inst.opd.rk;

  assign exc = '{sys: is_sys & valid, brk: is_brk & valid, ine: ~hit & valid};

endmodule

/* issue_pack.sv */
module issue_pack (
  input  logic              valid,
  input  logic              pause,
  input  logic              ex_allow_in,
  input  id_pkg::dec_ctrl_t dec,
  input  id_pkg::exc_vec_t  exc,
  input  id_pkg::word_t     pc,
  input  id_pkg::word_t     rj_value,
  input  id_pkg::word_t     rkd_value,
  output id_pkg::id_ex_t    id_ex,
  output logic              id_valid,
  output logic              ready_go,
  output logic              allow_in
);
  import id_pkg::*;

  word_t imm;

  always_comb
  begin
    case (dec.imm_kind)
      IMM_UI5:  imm = {27'b0, dec.imm_field[14:10]};
      IMM_UI12: imm = {20'b0, dec.imm_field[21:10]};
      IMM_SI12: imm = {{20{dec.imm_field[21]}}, dec.imm_field[21:10]};
      IMM_SI20: imm = {dec.imm_field[24:5], 12'b0};
      IMM_FOUR: imm = LINK_OFFSET;
      default:  imm = '0;
    endcase
  end

  always_comb
  begin
    // ALU sources also feed the multiplier and divider
    id_ex.alu_op       = dec.alu_op;
    id_ex.alu_src1     = dec.src1_is_pc ? pc : rj_value;
    id_ex.alu_src2     = dec.src2_is_imm ? imm : rkd_value;
    id_ex.mul          = dec.mul;
    id_ex.div          = dec.div;
    id_ex.exc          = exc;
    id_ex.mem.mem_en   = dec.mem_en;
    id_ex.mem.st_ctrl  = dec.st_ctrl;
    id_ex.mem.ld_ctrl  = dec.ld_ctrl;
    id_ex.mem.st_data  = rkd_value;
    id_ex.rf_we        = dec.gr_we & valid;
    id_ex.res_from_mem = dec.res_from_mem;
    id_ex.rf_waddr     = dec.dest;
    id_ex.pc           = pc;
  end

  // An unknown opcode travels on only as its exception flag
  assign id_valid = valid & ~exc.ine;
  assign ready_go = ~pause;
  assign allow_in = ~id_valid | (ex_allow_in & ready_go);

endmodule

/* operand_fetch.sv */
module operand_fetch (
  input  id_pkg::word_t      rf_rdata1,
  input  id_pkg::word_t      rf_rdata2,
  input  logic               fwd1_hit,
  input  logic               fwd2_hit,
  input  id_pkg::word_t      fwd1_data,
  input  id_pkg::word_t      fwd2_data,
  output id_pkg::word_t      rj_value,
  output id_pkg::word_t      rkd_value,
  output id_pkg::cmp_flags_t cmp
);

  // A younger result in flight overrides the register file
  assign rj_value  = fwd1_hit ? fwd1_data : rf_rdata1;
  assign rkd_value = fwd2_hit ? fwd2_data : rf_rdata2;

  assign cmp = '{
    eq:   rj_value == rkd_value,
    lt_s: $signed(rj_value) < $signed(rkd_value),
    lt_u: rj_value < rkd_value
  };

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the decode-stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
  --top-module tb_id_stage -f verilog.f > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  echo "Build failed, see $BUILD_LOG"
  exit 1
fi

./obj_dir/Vtb_id_stage +verilator+error+limit+1000 > "$SIM_LOG" 2>&1
sim_status=$?
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status, see $SIM_LOG"
  exit 1
fi

if grep -qx "Test completed successfully" "$SIM_LOG"; then
  echo "PASS"
  exit 0
fi
echo "FAIL, see $SIM_LOG"
exit 1

/* tb_id_stage.sv */
module tb_id_stage;
  timeunit 1ns;
  timeprecision 1ps;
  import id_pkg::*;

  localparam int PERIOD          = 40;
  localparam int RESET_CYCLES    = 16;
  localparam int N_CLASSES       = 9;
  localparam int N_ITER          = 270;
  localparam int MAX_ITER_CYCLES = 6;
  localparam int MARGIN_CYCLES   = 50;
  localparam int TIMEOUT_NS      =
    (RESET_CYCLES + N_ITER * MAX_ITER_CYCLES + MARGIN_CYCLES) * PERIOD;

  localparam logic [4:0] REG3_F5 [14] = '{F5_ADD, F5_SUB, F5_SLT, F5_SLTU, F5_NOR, F5_AND,
    F5_OR, F5_XOR, F5_SLL, F5_SRL, F5_SRA, F5_MUL, F5_MULH, F5_MULHU};
  localparam logic [4:0] DIV_F5 [6] = '{F5_DIV, F5_MOD, F5_DIVU, F5_MODU, F5_BREAK,
    F5_SYSCALL};
  localparam logic [4:0] SHIFT_F5 [3] = '{F5_SLLI, F5_SRLI, F5_SRAI};
  localparam logic [3:0] IMM_OP4 [6] = '{OP4_SLTI, OP4_SLTUI, OP4_ADDI, OP4_ANDI, OP4_ORI,
    OP4_XORI};
  localparam logic [3:0] MEM_OP4 [8] = '{OP4_LD_B, OP4_LD_H, OP4_LD_W, OP4_ST_B, OP4_ST_H,
    OP4_ST_W, OP4_LD_BU, OP4_LD_HU};

  logic      clk;
  logic      reset;
  logic      valid;
  inst_pc_t  inst_pc;
  logic      ex_allow_in;
  logic      pause;
  logic      fwd1_hit;
  logic      fwd2_hit;
  word_t     fwd1_data;
  word_t     fwd2_data;
  word_t     rf_rdata1;
  word_t     rf_rdata2;
  reg_addr_t rf_raddr1;
  reg_addr_t rf_raddr2;
  logic      id_valid;
  id_ex_t    id_ex;
  br_bus_t   br;
  logic      ready_go;
  logic      allow_in;

  id_stage DUT (
    .clk         (clk),
    .reset       (reset),
    .valid       (valid),
    .inst_pc     (inst_pc),
    .ex_allow_in (ex_allow_in),
    .pause       (pause),
    .fwd1_hit    (fwd1_hit),
    .fwd2_hit    (fwd2_hit),
    .fwd1_data   (fwd1_data),
    .fwd2_data   (fwd2_data),
    .rf_rdata1   (rf_rdata1),
    .rf_rdata2   (rf_rdata2),
    .rf_raddr1   (rf_raddr1),
    .rf_raddr2   (rf_raddr2),
    .id_valid    (id_valid),
    .id_ex       (id_ex),
    .br          (br),
    .ready_go    (ready_go),
    .allow_in    (allow_in)
  );

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic load_inputs(input word_t w);
    word_t pc;
    pc = $urandom();
    inst_pc.inst = w;
    inst_pc.pc = {pc[31:2], 2'b00};
    rf_rdata1 = $urandom();
    // Equal operands now and then so eq/ne go both ways
    rf_rdata2 = ($urandom_range(3) == 0) ? rf_rdata1 : $urandom();
    fwd1_hit = $urandom_range(3) == 0;
    fwd2_hit = $urandom_range(3) == 0;
    fwd1_data = $urandom();
    fwd2_data = $urandom();
    valid = $urandom_range(7) != 0;
    ex_allow_in = $urandom_range(3) != 0;
    pause = $urandom_range(7) == 0;
  endtask

  // Random word with the opcode fields of one instruction class laid over it
  task automatic run_class(input int cls);
    word_t w;
    int    idx;
    w = $urandom();
    case (cls)
      0:
      begin
        idx = $urandom_range(13);
        w[31:15] = {OP6_ALU, OP4_REG, OP2_3R, REG3_F5[idx]};
      end
      1:
      begin
        idx = $urandom_range(5);
        w[31:15] = {OP6_ALU, OP4_REG, OP2_DIV, DIV_F5[idx]};
      end
      2:
      begin
        idx = $urandom_range(2);
        w[31:15] = {OP6_ALU, OP4_SHIFT_I, OP2_SHIFT_I, SHIFT_F5[idx]};
      end
      3:
      begin
        idx = $urandom_range(5);
        w[31:22] = {OP6_ALU, IMM_OP4[idx]};
      end
      4:
        w[31:25] = {($urandom_range(1) == 0) ? OP6_LU12I : OP6_PCADDU12I, 1'b0};
      5:
      begin
        idx = $urandom_range(7);
        w[31:22] = {OP6_MEM, MEM_OP4[idx]};
      end
      7:
      begin
        idx = $urandom_range(2);
        if (idx == 0)
          w[31:30] = 2'b11;
        else if (idx == 1)
          w[31:22] = {OP6_ALU, 4'h3};
        else
          w[31:25] = {OP6_LU12I, 1'b1};
      end
      default:
      begin
        idx = $urandom_range(8);
        w[31:26] = OP6_JIRL + 6'(idx);
      end
    endcase
    load_inputs(w);
    if (cls == 6)
    begin
      // Same branch held, then stalled once and released
      valid = 1'b1;
      pause = 1'b0;
      repeat (4) next_cycle();
      pause = 1'b1;
      next_cycle();
      pause = 1'b0;
      next_cycle();
    end
    else if (cls == 8)
    begin
      valid = 1'b1;
      pause = 1'b1;
      next_cycle();
      pause = 1'b0;
      next_cycle();
    end
    else
      next_cycle();
  endtask

  initial
  begin
    void'($urandom(32'hf232));
    reset = 1'b1;
    valid = 1'b1;
    ex_allow_in = 1'b1;
    pause = 1'b0;
    fwd1_hit = 1'b0;
    fwd2_hit = 1'b0;
    fwd1_data = '0;
    fwd2_data = '0;
    rf_rdata1 = '0;
    rf_rdata2 = '0;
    // Unconditional b held across the end of reset
    inst_pc.inst = {OP6_B, 26'h0000100};
    inst_pc.pc = 32'h1c00_0000;
    repeat (RESET_CYCLES) next_cycle();
    reset = 1'b0;
    repeat (3) next_cycle();
    for (int i = 0; i < N_ITER; i++)
      run_class(i % N_CLASSES);
    repeat (2) next_cycle();
    if (DUT.u_checker.fail_count == 0)
    begin
      $display("Test completed successfully");
      $finish;
    end
    else
    begin
      $display("Test failed");
      $fatal(1, "checker reported %0d assertion failures", DUT.u_checker.fail_count);
    end
  end

  initial
  begin
    wait (DUT.u_checker.fail_count != 0);
    $display("Test failed");
    $fatal(1, "an assertion in the checker failed at %0t", $time);
  end

  initial
  begin
    #(TIMEOUT_NS);
    $display("Test failed");
    $fatal(1, "run did not finish within %0d ns", TIMEOUT_NS);
  end

endmodule

/* verilog.f */
id_pkg.sv
inst_decoder.sv
operand_fetch.sv
branch_unit.sv
issue_pack.sv
id_stage.sv
id_checker.sv
tb_id_stage.sv
